// File: src/fetch_pkg.sv
package fetch_pkg;

  typedef logic [31:0] word_t;

  localparam word_t START_ADDR = 32'h00001000;

  // requests per burst
  localparam int BURST_LEN = 4;

  // fetch FIFO sizing
  localparam int FIFO_AW    = 4;
  localparam int FIFO_DEPTH = 1 << FIFO_AW;

  // wide enough to count BURST_LEN requests or acks
  localparam int BURST_CW = $clog2(BURST_LEN + 1);

  // master to slave, read only
  typedef struct packed {
    logic  cyc;
    logic  stb;
    word_t adr;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic  ack;
    logic  stall;
    word_t dat;
  } wb_rsp_t;

  // core side, ir[63:32] is the second word or zero
  typedef struct packed {
    logic        valid;
    word_t       pc;
    logic [63:0] ir;
  } fetch_out_t;

endpackage

// File: src/fetch_bus_requester.sv
`timescale 1ns/100ps

module fetch_bus_requester
  import fetch_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             pc_set_i,
  input  word_t            pc_in_i,
  input  logic             halt_i,
  input  logic [FIFO_AW:0] fifo_level_i,
  output wb_req_t          bus_req_o,
  input  wb_rsp_t          bus_rsp_i,
  output logic             push_o,
  output word_t            push_data_o
);

  typedef enum logic [1:0] {S_IDLE, S_FETCH, S_END, S_DRAIN} state_t;

  state_t              state, state_next;
  word_t               adr, adr_next;
  logic [BURST_CW-1:0] req_cnt, req_cnt_next;
  logic [BURST_CW-1:0] ack_cnt, ack_cnt_next;
  logic                accept;
  logic                ack_seen;
  logic                room;
  logic                settled;

  assign accept   = (state == S_FETCH) && !bus_rsp_i.stall;
  assign ack_seen = bus_rsp_i.ack && (state != S_IDLE);

  // a full burst must fit behind what is already buffered
  assign room = (int'(fifo_level_i) + BURST_LEN) <= FIFO_DEPTH;

  // counts including this cycle's request and ack
  assign settled = (req_cnt + BURST_CW'(accept)) == (ack_cnt + BURST_CW'(ack_seen));

  always_comb
  begin
    state_next   = state;
    adr_next     = adr;
    req_cnt_next = req_cnt + BURST_CW'(accept);
    ack_cnt_next = ack_cnt + BURST_CW'(ack_seen);

    case (state)
      S_IDLE:
      begin
        req_cnt_next = '0;
        ack_cnt_next = '0;
        if (!halt_i && room)
          state_next = S_FETCH;
      end
      S_FETCH:
      begin
        if (accept)
        begin
          adr_next = adr + 32'h4;
          if (req_cnt == BURST_CW'(BURST_LEN - 1))
            state_next = S_END; // last request of the burst
        end
      end
      S_END:
      begin
        if (settled)
          state_next = S_IDLE;
      end
      S_DRAIN:
      begin
        if (settled)
        begin
          req_cnt_next = '0;
          ack_cnt_next = '0;
          state_next   = halt_i ? S_IDLE : S_FETCH; // fifo is empty here
        end
      end
      default:
        state_next = S_IDLE;
    endcase

    // redirect, stale acks still have to be counted off the bus
    if (pc_set_i)
    begin
      adr_next = pc_in_i;
      if (state == S_IDLE || settled)
      begin
        req_cnt_next = '0;
        ack_cnt_next = '0;
        state_next   = halt_i ? S_IDLE : S_FETCH;
      end
      else
        state_next = S_DRAIN;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state   <= S_IDLE;
      adr     <= START_ADDR;
      req_cnt <= '0;
      ack_cnt <= '0;
    end
    else
    begin
      state   <= state_next;
      adr     <= adr_next;
      req_cnt <= req_cnt_next;
      ack_cnt <= ack_cnt_next;
    end
  end

  always_comb
  begin
    bus_req_o.cyc = (state != S_IDLE); // held until the last ack
    bus_req_o.stb = (state == S_FETCH);
    bus_req_o.adr = adr;
  end

  // drop anything acked while draining or redirecting
  assign push_o      = bus_rsp_i.ack && (state inside {S_FETCH, S_END}) && !pc_set_i;
  assign push_data_o = bus_rsp_i.dat;

endmodule

// File: src/fetch_fifo.sv
`timescale 1ns/100ps

module fetch_fifo
  import fetch_pkg::*;
#(
  parameter type payload_t = word_t
)
(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  input  logic             push_i,
  input  payload_t         push_data_i,
  input  logic             pop_i,
  output payload_t         pop_data_o,
  output logic             empty_o,
  output logic [FIFO_AW:0] level_o
);

  payload_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               do_push;
  logic               do_pop;

  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i && (count != '0);

  always_ff @(posedge clk_i)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr <= '0; // flush wins over push and pop
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (FIFO_AW + 1)'(do_push) - (FIFO_AW + 1)'(do_pop);
    end
  end

  assign pop_data_o = mem[rd_ptr]; // no bypass from the write side
  assign empty_o    = (count == '0);
  assign level_o    = count;

endmodule

// File: src/insn_assembler.sv
`timescale 1ns/100ps

module insn_assembler
  import fetch_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       pc_set_i,
  input  word_t      pc_in_i,
  input  logic       stall_i,
  output logic       pop_o,
  input  word_t      word_i,
  input  logic       empty_i,
  output fetch_out_t fetch_o
);

  typedef enum logic {S_FIRST, S_SECOND} state_t;

  state_t     state, state_next;
  word_t      pc, pc_next;
  word_t      low, low_next;
  fetch_out_t fetch_next;

  // head word is consumed whenever the core side can move
  assign pop_o = !pc_set_i && !stall_i && !empty_i;

  always_comb
  begin
    state_next = state;
    pc_next    = pc;
    low_next   = low;
    fetch_next = fetch_o;

    if (pc_set_i)
    begin
      state_next       = S_FIRST;
      pc_next          = pc_in_i;
      fetch_next.valid = 1'b0;
    end
    else if (!stall_i)
    begin
      fetch_next.valid = 1'b0;
      if (!empty_i)
      begin
        case (state)
          S_FIRST:
          begin
            if (word_i[0])
            begin
              low_next   = word_i; // wait for the high word
              state_next = S_SECOND;
            end
            else
            begin
              fetch_next.valid = 1'b1;
              fetch_next.pc    = pc;
              fetch_next.ir    = {32'h0, word_i};
              pc_next          = pc + 32'h4;
            end
          end
          S_SECOND:
          begin
            fetch_next.valid = 1'b1;
            fetch_next.pc    = pc;
            fetch_next.ir    = {word_i, low};
            pc_next          = pc + 32'h8;
            state_next       = S_FIRST;
          end
          default:
            state_next = S_FIRST;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    low <= low_next;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state   <= S_FIRST;
      pc      <= START_ADDR;
      fetch_o <= '0;
    end
    else
    begin
      state   <= state_next;
      pc      <= pc_next;
      fetch_o <= fetch_next;
    end
  end

endmodule

// File: src/ifetch_top.sv
`timescale 1ns/100ps

module ifetch_top
  import fetch_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       pc_set_i,
  input  word_t      pc_in_i,
  input  logic       halt_i,
  input  logic       stall_i,
  output wb_req_t    bus_req_o,
  input  wb_rsp_t    bus_rsp_i,
  output fetch_out_t fetch_o
);

  logic             push;
  word_t            push_data;
  logic [FIFO_AW:0] fifo_level;
  logic             pop;
  word_t            fifo_data;
  logic             fifo_empty;

  fetch_bus_requester u_requester (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .pc_set_i     (pc_set_i),
    .pc_in_i      (pc_in_i),
    .halt_i       (halt_i),
    .fifo_level_i (fifo_level),
    .bus_req_o    (bus_req_o),
    .bus_rsp_i    (bus_rsp_i),
    .push_o       (push),
    .push_data_o  (push_data)
  );

  fetch_fifo #(
    .payload_t (word_t)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (pc_set_i), // old stream is dropped on redirect
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (fifo_data),
    .empty_o     (fifo_empty),
    .level_o     (fifo_level)
  );

  insn_assembler u_assembler (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .pc_set_i (pc_set_i),
    .pc_in_i  (pc_in_i),
    .stall_i  (stall_i),
    .pop_o    (pop),
    .word_i   (fifo_data),
    .empty_i  (fifo_empty),
    .fetch_o  (fetch_o)
  );

endmodule

// File: dv/ifetch_mem_model.sv
`timescale 1ns/100ps

module ifetch_mem_model
  import fetch_pkg::*;
#(
  parameter int MEM_AW    = 8,
  parameter int DRIVE_DLY = 2
)
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    redirect_i,
  input  word_t   image_i [1 << MEM_AW],
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,
  output int      errors_o
);

  word_t   pend_adr [$];
  int      pend_due [$];
  int      cycle;
  int      due;
  int      last_due;
  logic    have_prev;
  word_t   next_adr;
  wb_rsp_t rsp_next;

  function automatic word_t read_word(word_t adr);
    return image_i[adr[MEM_AW+1:2]]; // table wraps
  endfunction

  initial
  begin
    rsp_o     = '0;
    errors_o  = 0;
    cycle     = 0;
    last_due  = 0;
    have_prev = 1'b0;
    next_adr  = '0;
    forever
    begin
      @(posedge clk_i);
      cycle++;
      rsp_next = '0;
      if (rst_i)
      begin
        pend_adr.delete();
        pend_due.delete();
        have_prev = 1'b0;
        last_due  = cycle;
      end
      else
      begin
        if (!req_i.cyc && pend_adr.size() != 0)
        begin
          errors_o++;
          $display("bus: cyc dropped with %0d acks outstanding", pend_adr.size());
        end
        if (!req_i.cyc)
          have_prev = 1'b0;
        if (req_i.cyc && req_i.stb && !rsp_o.stall)
        begin
          if (have_prev && req_i.adr != next_adr)
          begin
            errors_o++;
            $display("mismatch bus_req_o.adr: got %h, expected %h", req_i.adr, next_adr);
          end
          have_prev = 1'b1;
          next_adr  = req_i.adr + 32'h4;
          due       = cycle + int'($urandom_range(1, 3));
          if (due <= last_due)
            due = last_due + 1; // acks stay in order
          last_due = due;
          pend_adr.push_back(req_i.adr);
          pend_due.push_back(due);
          if (pend_adr.size() > BURST_LEN)
          begin
            errors_o++;
            $display("bus: %0d requests outstanding, limit is %0d", pend_adr.size(), BURST_LEN);
          end
        end
        if (redirect_i)
          have_prev = 1'b0; // new stream starts anywhere
        if (pend_due.size() != 0 && pend_due[0] == cycle + 1)
        begin
          rsp_next.ack = 1'b1;
          rsp_next.dat = read_word(pend_adr.pop_front());
          void'(pend_due.pop_front());
        end
        rsp_next.stall = ($urandom_range(0, 3) == 0);
      end
      #(DRIVE_DLY);
      rsp_o = rsp_next;
    end
  end

endmodule

// File: dv/tb_ifetch.sv
`timescale 1ns/100ps

module tb_ifetch
  import fetch_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int DRIVE_DLY     = 2;
  localparam int RESET_CYCLES  = 16;
  localparam int SEED          = 54;
  localparam int MEM_AW        = 8;
  localparam int MEM_WORDS     = 1 << MEM_AW;
  localparam int RUN_CYCLES    = 3000;
  localparam int FIRST_TIMEOUT = 50;
  localparam int FINAL_INSNS   = 16;
  localparam int FINAL_TIMEOUT = 200;
  localparam int MIN_INSNS     = 200;

  logic       clk;
  logic       rst;
  logic       pc_set;
  word_t      pc_in;
  logic       halt;
  logic       stall;
  wb_req_t    bus_req;
  wb_rsp_t    bus_rsp;
  fetch_out_t fetch;
  word_t      image [MEM_WORDS];

  int         check_errors;
  int         run_errors;
  int         bus_errors;
  int         consumed;
  word_t      exp_pc;
  fetch_out_t prev_fetch;
  logic       prev_stall;
  logic       prev_set;
  logic       prev_rst;
  logic       halt_quiet;

  ifetch_top u_ifetch_top (
    .clk_i     (clk),
    .rst_i     (rst),
    .pc_set_i  (pc_set),
    .pc_in_i   (pc_in),
    .halt_i    (halt),
    .stall_i   (stall),
    .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp),
    .fetch_o   (fetch)
  );

  ifetch_mem_model #(
    .MEM_AW    (MEM_AW),
    .DRIVE_DLY (DRIVE_DLY)
  ) u_mem (
    .clk_i      (clk),
    .rst_i      (rst),
    .redirect_i (pc_set),
    .image_i    (image),
    .req_i      (bus_req),
    .rsp_o      (bus_rsp),
    .errors_o   (bus_errors)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t image_word(word_t adr);
    return image[adr[MEM_AW+1:2]];
  endfunction

  // one instruction taken by the core, compared with the walk of the table
  task automatic check_insn();
    word_t       w0;
    logic [63:0] exp_ir;
    w0 = image_word(exp_pc);
    if (w0[0])
      exp_ir = {image_word(exp_pc + 32'h4), w0}; // two-word instruction
    else
      exp_ir = {32'h0, w0};
    if (fetch.pc !== exp_pc)
    begin
      check_errors++;
      $display("mismatch fetch_o.pc: got %h, expected %h", fetch.pc, exp_pc);
    end
    if (fetch.ir !== exp_ir)
    begin
      check_errors++;
      $display("mismatch fetch_o.ir: got %h, expected %h", fetch.ir, exp_ir);
    end
    exp_pc = exp_pc + (w0[0] ? 32'h8 : 32'h4);
    consumed++;
  endtask

  initial
  begin
    check_errors = 0;
    consumed     = 0;
    exp_pc       = START_ADDR;
    prev_fetch   = '0;
    prev_stall   = 1'b0;
    prev_set     = 1'b0;
    prev_rst     = 1'b1;
    halt_quiet   = 1'b0;
    forever
    begin
      @(posedge clk);
      if ((rst || prev_rst) && (bus_req.cyc || bus_req.stb || fetch.valid))
      begin
        check_errors++;
        $display("bus or fetch output active during or right after reset");
      end
      if (rst)
      begin
        exp_pc     = START_ADDR;
        halt_quiet = 1'b0;
      end
      else
      begin
        if (prev_set && fetch.valid)
        begin
          check_errors++;
          $display("fetch_o.valid still high on the cycle after a redirect");
        end
        if (prev_stall && !prev_set && fetch !== prev_fetch)
        begin
          check_errors++;
          $display("mismatch fetch_o during stall: got %h, expected %h", fetch, prev_fetch);
        end
        if (fetch.valid && !stall)
          check_insn();
        if (halt_quiet && bus_req.stb)
        begin
          check_errors++;
          $display("stb raised while halted after the burst had ended");
        end
        halt_quiet = halt && (halt_quiet || !bus_req.cyc);
        if (pc_set)
          exp_pc = pc_in; // walk restarts at the target
      end
      prev_fetch = fetch;
      prev_stall = stall;
      prev_set   = pc_set;
      prev_rst   = rst;
    end
  end

  initial
  begin
    int idx;
    int cyc_cnt;
    int halt_left;
    int wait_cnt;
    int start_cnt;
    void'($urandom(SEED));
    run_errors = 0;
    rst        = 1'b1;
    pc_set     = 1'b0;
    pc_in      = '0;
    halt       = 1'b0;
    stall      = 1'b0;
    for (idx = 0; idx < MEM_WORDS; idx++)
      image[idx] = $urandom() ^ (START_ADDR + (word_t'(idx) << 2));

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;

    wait_cnt = 0;
    while (consumed == 0 && wait_cnt < FIRST_TIMEOUT)
    begin
      @(posedge clk);
      #(DRIVE_DLY);
      wait_cnt++;
    end
    if (consumed == 0)
    begin
      run_errors++;
      $display("timeout: no instruction after reset within %0d cycles", FIRST_TIMEOUT);
    end

    halt_left = 0;
    for (cyc_cnt = 0; cyc_cnt < RUN_CYCLES; cyc_cnt++)
    begin
      @(posedge clk);
      #(DRIVE_DLY);
      stall  = ($urandom_range(0, 99) < 30);
      pc_set = ($urandom_range(0, 99) < 2);
      if (pc_set)
        pc_in = START_ADDR + (word_t'($urandom_range(0, MEM_WORDS - 1)) << 2);
      if (halt_left > 0)
        halt_left--;
      else if ($urandom_range(0, 99) == 0)
        halt_left = $urandom_range(4, 24); // short halt window
      halt = (halt_left > 0);
    end

    // quiet redirect, then the stream has to keep flowing
    @(posedge clk);
    #(DRIVE_DLY);
    stall  = 1'b0;
    halt   = 1'b0;
    pc_set = 1'b1;
    pc_in  = START_ADDR;
    @(posedge clk);
    #(DRIVE_DLY);
    pc_set    = 1'b0;
    start_cnt = consumed;
    wait_cnt  = 0;
    while (consumed - start_cnt < FINAL_INSNS && wait_cnt < FINAL_TIMEOUT)
    begin
      @(posedge clk);
      #(DRIVE_DLY);
      wait_cnt++;
    end
    if (consumed - start_cnt < FINAL_INSNS)
    begin
      run_errors++;
      $display("timeout: only %0d instructions after the last redirect", consumed - start_cnt);
    end
    if (consumed < MIN_INSNS)
    begin
      run_errors++;
      $display("too few instructions checked: %0d, at least %0d needed", consumed, MIN_INSNS);
    end

    repeat (4) @(posedge clk);
    #(DRIVE_DLY);
    $display("errors: checks %0d, run %0d, bus %0d; instructions checked %0d",
             check_errors, run_errors, bus_errors, consumed);
    if (check_errors == 0 && run_errors == 0 && bus_errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: src.f
src/fetch_pkg.sv
src/fetch_bus_requester.sv
src/fetch_fifo.sv
src/insn_assembler.sv
src/ifetch_top.sv
dv/ifetch_mem_model.sv
dv/tb_ifetch.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_ifetch -f src.f
./obj_dir/Vtb_ifetch > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
